// ==== source/matrix_ctrl_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// matrix control package
// panel geometry, payload types and command byte codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package matrix_ctrl_pkg;

    localparam int unsigned PIXEL_WIDTH = 64;
    localparam int unsigned PIXEL_HEIGHT = 32;
    localparam int unsigned BYTES_PER_PIXEL = 2;

    localparam int unsigned ROW_BITS = $clog2(PIXEL_HEIGHT);
    localparam int unsigned COL_BITS = $clog2(PIXEL_WIDTH);
    localparam int unsigned BYTE_SEL_BITS = $clog2(BYTES_PER_PIXEL);
    localparam int unsigned RAM_ADDR_BITS = ROW_BITS + COL_BITS + BYTE_SEL_BITS;
    localparam int unsigned RAM_WORDS = 1 << RAM_ADDR_BITS;

    localparam int unsigned BRIGHTNESS_LEVELS = 6;

    // byte select is stored inverted, data byte 0 lands on select 1
    typedef struct packed {
        logic [ROW_BITS-1:0] row;
        logic [COL_BITS-1:0] col;
        logic [BYTE_SEL_BITS-1:0] byte_sel;
    } ram_addr_t;

    typedef logic [BRIGHTNESS_LEVELS-1:0] brightness_t;

    typedef struct packed {
        logic [8-BRIGHTNESS_LEVELS-1:0] spare;
        brightness_t planes;
    } brightness_arg_t;

    // first argument byte sits in the top field
    typedef struct packed {
        logic [7:0] row;
        logic [7:0] col;
        logic [7:0] data0;
        logic [7:0] data1;
    } pixel_arg_t;

    typedef enum logic [2:0] {
        OP_NONE,
        OP_SET_CHANNEL,
        OP_CLEAR_CHANNEL,
        OP_TOGGLE_PLANE,
        OP_PLANES_OFF,
        OP_PLANES_ON
    } settings_op_t;

    localparam logic [7:0] CMD_RED_ON = "R";
    localparam logic [7:0] CMD_RED_OFF = "r";
    localparam logic [7:0] CMD_GREEN_ON = "G";
    localparam logic [7:0] CMD_GREEN_OFF = "g";
    localparam logic [7:0] CMD_BLUE_ON = "B";
    localparam logic [7:0] CMD_BLUE_OFF = "b";
    localparam logic [7:0] CMD_PLANE_FIRST = "1";
    localparam logic [7:0] CMD_PLANE_LAST = "6";
    localparam logic [7:0] CMD_PLANES_OFF = "0";
    localparam logic [7:0] CMD_PLANES_ON = "9";
    localparam logic [7:0] CMD_BRIGHTNESS = "T";
    localparam logic [7:0] CMD_PIXEL = "P";
    localparam logic [7:0] CMD_BLANK = "Z";

endpackage

// ==== source/command_decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command decoder
// captures accepted bytes and dispatches them to the stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module command_decoder (
    input  logic                          clk_in,
    input  logic                          reset,
    input  logic [7:0]                    data_rx,
    input  logic                          data_ready_n,
    output logic                          ready_for_data,
    output logic                          busy,
    output matrix_ctrl_pkg::settings_op_t settings_op,
    output logic [2:0]                    settings_index,
    output logic [7:0]                    arg_byte,
    output logic                          arg_valid_bright,
    output logic                          arg_valid_pixel,
    output logic                          blank_start,
    input  logic                          blank_done
);
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BRIGHT_ARG,
        ST_PIXEL_ARG,
        ST_BLANK_WAIT
    } state_t;

    state_t state;
    logic accept;
    logic [7:0] byte_q;
    logic byte_valid;
    logic blank_pending;
    logic [1:0] pixel_count;
    matrix_ctrl_pkg::settings_op_t dec_op;
    logic [2:0] dec_index;

    assign accept = ~data_ready_n && ready_for_data;

    // a captured Z stalls the source before the state catches up
    assign blank_pending = byte_valid && (state == ST_IDLE) && (byte_q == matrix_ctrl_pkg::CMD_BLANK);
    assign ready_for_data = ~((state == ST_BLANK_WAIT) || blank_pending);
    assign busy = (state != ST_IDLE) || blank_pending;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= accept;
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            byte_q <= data_rx;
        end
    end

    // one-byte commands
    always_comb begin
        dec_op = matrix_ctrl_pkg::OP_NONE;
        dec_index = 3'd0;
        case (byte_q) inside
            matrix_ctrl_pkg::CMD_RED_ON: begin
                dec_op = matrix_ctrl_pkg::OP_SET_CHANNEL;
                dec_index = 3'd0;
            end
            matrix_ctrl_pkg::CMD_RED_OFF: begin
                dec_op = matrix_ctrl_pkg::OP_CLEAR_CHANNEL;
                dec_index = 3'd0;
            end
            matrix_ctrl_pkg::CMD_GREEN_ON: begin
                dec_op = matrix_ctrl_pkg::OP_SET_CHANNEL;
                dec_index = 3'd1;
            end
            matrix_ctrl_pkg::CMD_GREEN_OFF: begin
                dec_op = matrix_ctrl_pkg::OP_CLEAR_CHANNEL;
                dec_index = 3'd1;
            end
            matrix_ctrl_pkg::CMD_BLUE_ON: begin
                dec_op = matrix_ctrl_pkg::OP_SET_CHANNEL;
                dec_index = 3'd2;
            end
            matrix_ctrl_pkg::CMD_BLUE_OFF: begin
                dec_op = matrix_ctrl_pkg::OP_CLEAR_CHANNEL;
                dec_index = 3'd2;
            end
            [matrix_ctrl_pkg::CMD_PLANE_FIRST:matrix_ctrl_pkg::CMD_PLANE_LAST]: begin
                dec_op = matrix_ctrl_pkg::OP_TOGGLE_PLANE;
                dec_index = 3'(byte_q - matrix_ctrl_pkg::CMD_PLANE_FIRST);
            end
            matrix_ctrl_pkg::CMD_PLANES_OFF: dec_op = matrix_ctrl_pkg::OP_PLANES_OFF;
            matrix_ctrl_pkg::CMD_PLANES_ON: dec_op = matrix_ctrl_pkg::OP_PLANES_ON;
            default: dec_op = matrix_ctrl_pkg::OP_NONE;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (byte_valid) begin
            arg_byte <= byte_q;
            settings_index <= dec_index;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= ST_IDLE;
            pixel_count <= 2'd0;
            settings_op <= matrix_ctrl_pkg::OP_NONE;
            arg_valid_bright <= 1'b0;
            arg_valid_pixel <= 1'b0;
            blank_start <= 1'b0;
        end else begin
            settings_op <= matrix_ctrl_pkg::OP_NONE;
            arg_valid_bright <= 1'b0;
            arg_valid_pixel <= 1'b0;
            blank_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (byte_valid) begin
                        settings_op <= dec_op;
                        if (byte_q == matrix_ctrl_pkg::CMD_BRIGHTNESS) begin
                            state <= ST_BRIGHT_ARG;
                        end else if (byte_q == matrix_ctrl_pkg::CMD_PIXEL) begin
                            state <= ST_PIXEL_ARG;
                        end else if (byte_q == matrix_ctrl_pkg::CMD_BLANK) begin
                            state <= ST_BLANK_WAIT;
                            blank_start <= 1'b1;
                        end
                    end
                end
                ST_BRIGHT_ARG: begin
                    if (byte_valid) begin
                        arg_valid_bright <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                ST_PIXEL_ARG: begin
                    if (byte_valid) begin
                        arg_valid_pixel <= 1'b1;
                        pixel_count <= pixel_count + 2'd1;
                        // row, column and both data bytes
                        if (pixel_count == 2'($bits(matrix_ctrl_pkg::pixel_arg_t) / 8 - 1)) begin
                            pixel_count <= 2'd0;
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_BLANK_WAIT: begin
                    if (blank_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== source/arg_collector.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// argument collector
// shifts argument bytes into one payload of any byte width
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module arg_collector #(
    parameter type payload_t = logic [7:0]
) (
    input  logic       clk_in,
    input  logic       reset,
    input  logic [7:0] arg_byte,
    input  logic       arg_valid,
    output payload_t   payload,
    output logic       payload_valid
);
    localparam int unsigned PAYLOAD_BITS = $bits(payload_t);
    localparam int unsigned NUM_BYTES = PAYLOAD_BITS / 8;
    localparam int unsigned COUNT_BITS = (NUM_BYTES > 1) ? $clog2(NUM_BYTES) : 1;

    logic [PAYLOAD_BITS-1:0] shift_q;
    logic [COUNT_BITS-1:0] count;

    assign payload = payload_t'(shift_q);

    // earliest byte ends up in the top field
    always_ff @(posedge clk_in) begin
        if (arg_valid) begin
            shift_q <= (shift_q << 8) | PAYLOAD_BITS'(arg_byte);
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            count <= '0;
            payload_valid <= 1'b0;
        end else begin
            payload_valid <= 1'b0;
            if (arg_valid) begin
                if (count == COUNT_BITS'(NUM_BYTES - 1)) begin
                    count <= '0;
                    payload_valid <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

endmodule

// ==== source/display_settings.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// display settings
// colour channel enables and brightness plane enables
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module display_settings (
    input  logic                             clk_in,
    input  logic                             reset,
    input  matrix_ctrl_pkg::settings_op_t    settings_op,
    input  logic [2:0]                       settings_index,
    input  matrix_ctrl_pkg::brightness_arg_t payload,
    input  logic                             payload_valid,
    output logic [2:0]                       rgb_enable,
    output matrix_ctrl_pkg::brightness_t     brightness_enable
);
    logic [2:0] plane_sel;
    matrix_ctrl_pkg::brightness_t planes_base;
    matrix_ctrl_pkg::brightness_t planes_next;

    // "1" maps to the top plane
    assign plane_sel = 3'(matrix_ctrl_pkg::BRIGHTNESS_LEVELS - 1) - settings_index;

    // a T load and a following one-byte op can land on the same edge,
    // the op is applied on top of the loaded planes
    always_comb begin
        planes_base = payload_valid ? payload.planes : brightness_enable;
        planes_next = planes_base;
        case (settings_op)
            matrix_ctrl_pkg::OP_TOGGLE_PLANE: planes_next[plane_sel] = ~planes_base[plane_sel];
            matrix_ctrl_pkg::OP_PLANES_OFF: planes_next = '0;
            matrix_ctrl_pkg::OP_PLANES_ON: planes_next = '1;
            default: planes_next = planes_base;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            rgb_enable <= 3'b111;
            brightness_enable <= '1;
        end else begin
            brightness_enable <= planes_next;
            case (settings_op)
                matrix_ctrl_pkg::OP_SET_CHANNEL: rgb_enable[settings_index[1:0]] <= 1'b1;
                matrix_ctrl_pkg::OP_CLEAR_CHANNEL: rgb_enable[settings_index[1:0]] <= 1'b0;
                default: rgb_enable <= rgb_enable;
            endcase
        end
    end

endmodule

// ==== source/frame_ram_writer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame RAM writer
// pixel writes and the blank sweep onto one write port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module frame_ram_writer (
    input  logic                          clk_in,
    input  logic                          reset,
    input  matrix_ctrl_pkg::pixel_arg_t   payload,
    input  logic                          payload_valid,
    input  logic                          blank_start,
    output matrix_ctrl_pkg::ram_addr_t    ram_address,
    output logic [7:0]                    ram_data_out,
    output logic                          ram_write_enable,
    output logic                          blank_done
);
    matrix_ctrl_pkg::pixel_arg_t pending;
    logic second_phase;
    logic pixel_write;
    logic sweep_active;
    logic sweep_last;
    logic [matrix_ctrl_pkg::RAM_ADDR_BITS-1:0] sweep_addr;

    function automatic matrix_ctrl_pkg::ram_addr_t pixel_addr(
        input logic [7:0] row,
        input logic [7:0] col,
        input logic       byte_idx
    );
        matrix_ctrl_pkg::ram_addr_t addr;
        addr.row = row[matrix_ctrl_pkg::ROW_BITS-1:0];
        addr.col = col[matrix_ctrl_pkg::COL_BITS-1:0];
        addr.byte_sel = ~byte_idx;
        return addr;
    endfunction

    // pixel writes take the port, the sweep holds its place meanwhile
    assign pixel_write = payload_valid || second_phase;
    assign sweep_last = sweep_addr == matrix_ctrl_pkg::RAM_ADDR_BITS'(matrix_ctrl_pkg::RAM_WORDS - 1);

    always_ff @(posedge clk_in) begin
        if (payload_valid) begin
            pending <= payload;
            ram_address <= pixel_addr(payload.row, payload.col, 1'b0);
            ram_data_out <= payload.data0;
        end else if (second_phase) begin
            ram_address <= pixel_addr(pending.row, pending.col, 1'b1);
            ram_data_out <= pending.data1;
        end else if (sweep_active) begin
            ram_address <= matrix_ctrl_pkg::ram_addr_t'(sweep_addr);
            ram_data_out <= 8'd0;
        end
        if (blank_start) begin
            sweep_addr <= '0;
        end else if (sweep_active && !pixel_write) begin
            sweep_addr <= sweep_addr + 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            ram_write_enable <= 1'b0;
            second_phase <= 1'b0;
            sweep_active <= 1'b0;
            blank_done <= 1'b0;
        end else begin
            ram_write_enable <= pixel_write || sweep_active;
            second_phase <= payload_valid;
            blank_done <= 1'b0;
            if (blank_start) begin
                sweep_active <= 1'b1;
            end else if (sweep_active && !pixel_write && sweep_last) begin
                // done goes out with the last sweep write
                sweep_active <= 1'b0;
                blank_done <= 1'b1;
            end
        end
    end

endmodule

// ==== source/matrix_control_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LED matrix control top level
// decoder, argument collectors, settings and RAM writer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module matrix_control_top (
    input  logic                         clk_in,
    input  logic                         reset,
    input  logic [7:0]                   data_rx,
    input  logic                         data_ready_n,
    output logic [2:0]                   rgb_enable,
    output matrix_ctrl_pkg::brightness_t brightness_enable,
    output matrix_ctrl_pkg::ram_addr_t   ram_address,
    output logic [7:0]                   ram_data_out,
    output logic                         ram_write_enable,
    output logic                         ready_for_data,
    output logic                         busy
);
    matrix_ctrl_pkg::settings_op_t settings_op;
    logic [2:0] settings_index;
    logic [7:0] arg_byte;
    logic arg_valid_bright;
    logic arg_valid_pixel;
    logic blank_start;
    logic blank_done;
    matrix_ctrl_pkg::brightness_arg_t bright_payload;
    logic bright_payload_valid;
    matrix_ctrl_pkg::pixel_arg_t pixel_payload;
    logic pixel_payload_valid;

    command_decoder i_decoder (
        .clk_in          (clk_in),
        .reset           (reset),
        .data_rx         (data_rx),
        .data_ready_n    (data_ready_n),
        .ready_for_data  (ready_for_data),
        .busy            (busy),
        .settings_op     (settings_op),
        .settings_index  (settings_index),
        .arg_byte        (arg_byte),
        .arg_valid_bright(arg_valid_bright),
        .arg_valid_pixel (arg_valid_pixel),
        .blank_start     (blank_start),
        .blank_done      (blank_done)
    );

    arg_collector #(
        .payload_t(matrix_ctrl_pkg::brightness_arg_t)
    ) i_bright_collector (
        .clk_in       (clk_in),
        .reset        (reset),
        .arg_byte     (arg_byte),
        .arg_valid    (arg_valid_bright),
        .payload      (bright_payload),
        .payload_valid(bright_payload_valid)
    );

    arg_collector #(
        .payload_t(matrix_ctrl_pkg::pixel_arg_t)
    ) i_pixel_collector (
        .clk_in       (clk_in),
        .reset        (reset),
        .arg_byte     (arg_byte),
        .arg_valid    (arg_valid_pixel),
        .payload      (pixel_payload),
        .payload_valid(pixel_payload_valid)
    );

    display_settings i_settings (
        .clk_in           (clk_in),
        .reset            (reset),
        .settings_op      (settings_op),
        .settings_index   (settings_index),
        .payload          (bright_payload),
        .payload_valid    (bright_payload_valid),
        .rgb_enable       (rgb_enable),
        .brightness_enable(brightness_enable)
    );

    frame_ram_writer i_writer (
        .clk_in          (clk_in),
        .reset           (reset),
        .payload         (pixel_payload),
        .payload_valid   (pixel_payload_valid),
        .blank_start     (blank_start),
        .ram_address     (ram_address),
        .ram_data_out    (ram_data_out),
        .ram_write_enable(ram_write_enable),
        .blank_done      (blank_done)
    );

endmodule

// ==== verif/tb_clock_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock generator
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_clock_gen #(
    parameter int PERIOD = 8
) (
    output logic clk_in
);
    initial begin
        clk_in = 1'b0;
        forever #(PERIOD / 2) clk_in = ~clk_in;
    end
endmodule

// ==== verif/tb_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench checker
// compares RAM writes and panel settings with expected values
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_checker (
    input logic                                      clk_in,
    input logic                                      reset,
    input logic [2:0]                                rgb_enable,
    input logic [matrix_ctrl_pkg::BRIGHTNESS_LEVELS-1:0] brightness_enable,
    input logic [matrix_ctrl_pkg::RAM_ADDR_BITS-1:0] ram_address,
    input logic [7:0]                                ram_data_out,
    input logic                                      ram_write_enable,
    input logic                                      ready_for_data,
    input logic                                      busy
);
    // entry is {stall expected, address, data}
    logic [20:0] exp_q[$];
    string name_q[$];
    logic [20:0] entry;
    string entry_name;
    int write_errors = 0;
    int settings_errors = 0;

    task automatic expect_write(input string test_name, input logic [11:0] addr,
                                input logic [7:0] data, input logic stall);
        exp_q.push_back({stall, addr, data});
        name_q.push_back(test_name);
    endtask

    function automatic int pending_writes();
        return exp_q.size();
    endfunction

    task automatic compare_settings(input string test_name, input logic [2:0] exp_rgb,
                                    input logic [5:0] exp_bright);
        if (rgb_enable !== exp_rgb) begin
            settings_errors++;
            $display("** Error [%s] rgb_enable: expected %03b, actual %03b",
                     test_name, exp_rgb, rgb_enable);
        end
        if (brightness_enable !== exp_bright) begin
            settings_errors++;
            $display("** Error [%s] brightness_enable: expected %06b, actual %06b",
                     test_name, exp_bright, brightness_enable);
        end
        if (ready_for_data !== 1'b1 || busy !== 1'b0) begin
            settings_errors++;
            $display("** Error [%s] ready/busy when idle: expected 1/0, actual %b/%b",
                     test_name, ready_for_data, busy);
        end
    endtask

    // write strobe is registered, so the falling edge sees it settled
    always @(negedge clk_in) begin
        if (!reset && ram_write_enable) begin
            if (exp_q.size() == 0) begin
                write_errors++;
                $display("unexpected RAM write to address %03h while no write was due",
                         ram_address);
            end else begin
                entry = exp_q.pop_front();
                entry_name = name_q.pop_front();
                if ({ram_address, ram_data_out} !== entry[19:0]) begin
                    write_errors++;
                    $display("** Error [%s] ram write: expected %03h/%02h, actual %03h/%02h",
                             entry_name, entry[19:8], entry[7:0], ram_address, ram_data_out);
                end
                if (entry[20] && ready_for_data !== 1'b0) begin
                    write_errors++;
                    $display("ready_for_data was high during the blank sweep at address %03h",
                             ram_address);
                end
            end
        end
    end
endmodule

// ==== verif/matrix_control_asserts.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// matrix control assertions, bound to the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module matrix_control_asserts (
    input logic clk_in,
    input logic reset,
    input logic ram_write_enable,
    input logic ready_for_data,
    input logic busy
);
    no_write_in_reset: assert property (@(posedge clk_in) reset && $past(reset) |-> !ram_write_enable)
        else $error("RAM write strobe high while reset is held");

    stall_only_when_busy: assert property (@(posedge clk_in) disable iff (reset)
        !busy |-> ready_for_data)
        else $error("ready_for_data low while the decoder is not busy");

    write_strobe_known: assert property (@(posedge clk_in) disable iff (reset)
        !$isunknown(ram_write_enable))
        else $error("RAM write strobe is unknown");
endmodule

bind matrix_control_top matrix_control_asserts i_asserts (
    .clk_in          (clk_in),
    .reset           (reset),
    .ram_write_enable(ram_write_enable),
    .ready_for_data  (ready_for_data),
    .busy            (busy)
);

// ==== verif/tb_matrix_control.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// matrix control testbench
// random command stream against reference models
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_matrix_control;
    localparam int ONE_BYTE_TESTS = 40;
    localparam int BRIGHT_TESTS = 6;
    localparam int PIXEL_TESTS = 20;
    localparam int TOTAL_BYTES = ONE_BYTE_TESTS + BRIGHT_TESTS * 2 + PIXEL_TESTS * 5 + 1 + 5;
    localparam int TIMEOUT_CYCLES = TOTAL_BYTES * 8 + 2 * matrix_ctrl_pkg::RAM_WORDS + 500;

    logic clk_in;
    logic reset;
    logic [7:0] data_rx;
    logic data_ready_n;
    logic [2:0] rgb_enable;
    logic [matrix_ctrl_pkg::BRIGHTNESS_LEVELS-1:0] brightness_enable;
    logic [matrix_ctrl_pkg::RAM_ADDR_BITS-1:0] ram_address;
    logic [7:0] ram_data_out;
    logic ram_write_enable;
    logic ready_for_data;
    logic busy;

    logic [31:0] lcg_state = 32'd67241;
    int cycle_count = 0;
    logic [2:0] exp_rgb;
    logic [5:0] exp_bright;
    logic [7:0] cmd;
    logic [7:0] one_byte_cmds [14] = '{"R", "r", "G", "g", "B", "b",
                                       "1", "2", "3", "4", "5", "6", "0", "9"};

    tb_clock_gen #(.PERIOD(8)) i_clock (.clk_in(clk_in));

    matrix_control_top i_dut (
        .clk_in(clk_in), .reset(reset), .data_rx(data_rx), .data_ready_n(data_ready_n),
        .rgb_enable(rgb_enable), .brightness_enable(brightness_enable),
        .ram_address(ram_address), .ram_data_out(ram_data_out),
        .ram_write_enable(ram_write_enable), .ready_for_data(ready_for_data), .busy(busy)
    );

    tb_checker i_checker (
        .clk_in(clk_in), .reset(reset), .rgb_enable(rgb_enable),
        .brightness_enable(brightness_enable), .ram_address(ram_address),
        .ram_data_out(ram_data_out), .ram_write_enable(ram_write_enable),
        .ready_for_data(ready_for_data), .busy(busy)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // mostly real commands, now and then an unknown byte
    function automatic logic [7:0] pick_command(input logic [31:0] r);
        logic [7:0] b;
        if (r[30:28] == 3'd0) begin
            b = r[23:16];
            if (b == "T" || b == "P" || b == "Z") begin
                b = "?";
            end
        end else begin
            b = one_byte_cmds[r[27:20] % 14];
        end
        return b;
    endfunction

    // returns {rgb, planes} after one command byte
    function automatic logic [8:0] next_settings(input logic [8:0] cur, input logic [7:0] c);
        logic [2:0] rgb;
        logic [5:0] planes;
        int n;
        rgb = cur[8:6];
        planes = cur[5:0];
        case (c)
            "R": rgb[0] = 1'b1;
            "r": rgb[0] = 1'b0;
            "G": rgb[1] = 1'b1;
            "g": rgb[1] = 1'b0;
            "B": rgb[2] = 1'b1;
            "b": rgb[2] = 1'b0;
            "0": planes = 6'b000000;
            "9": planes = 6'b111111;
            default: begin
                if (c >= "1" && c <= "6") begin
                    n = int'(c) - int'("0");
                    planes[matrix_ctrl_pkg::BRIGHTNESS_LEVELS - n] =
                        ~planes[matrix_ctrl_pkg::BRIGHTNESS_LEVELS - n];
                end
            end
        endcase
        return {rgb, planes};
    endfunction

    // data byte 0 sits on the odd address
    function automatic logic [11:0] pixel_address(input logic [7:0] row, input logic [7:0] col,
                                                  input logic byte_idx);
        return {row[matrix_ctrl_pkg::ROW_BITS-1:0], col[matrix_ctrl_pkg::COL_BITS-1:0],
                ~byte_idx};
    endfunction

    task automatic send_byte(input logic [7:0] value);
        data_rx = value;
        data_ready_n = 1'b0;
        while (ready_for_data !== 1'b1) @(negedge clk_in);
        @(negedge clk_in);
        data_ready_n = 1'b1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk_in);
    endtask

    task automatic send_pixel(input string test_name, input logic [31:0] r);
        i_checker.expect_write(test_name, pixel_address(r[31:24], r[23:16], 1'b0), r[15:8], 1'b0);
        i_checker.expect_write(test_name, pixel_address(r[31:24], r[23:16], 1'b1), r[7:0], 1'b0);
        send_byte("P");
        send_byte(r[31:24]);
        send_byte(r[23:16]);
        send_byte(r[15:8]);
        send_byte(r[7:0]);
    endtask

    task automatic drain_writes();
        while (i_checker.pending_writes() != 0) @(negedge clk_in);
    endtask

    task automatic finish_run();
        int total;
        total = i_checker.write_errors + i_checker.settings_errors + i_checker.pending_writes();
        $display("error counts: writes %0d, settings %0d, missing writes %0d",
                 i_checker.write_errors, i_checker.settings_errors, i_checker.pending_writes());
        if (total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    always @(posedge clk_in) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        data_rx = 8'h00;
        data_ready_n = 1'b1;
        reset = 1'b1;
        exp_rgb = 3'b111;
        exp_bright = 6'b111111;
        repeat (10) @(negedge clk_in);
        reset = 1'b0;
        idle_cycles(4);
        i_checker.compare_settings("reset", exp_rgb, exp_bright);

        for (int i = 0; i < ONE_BYTE_TESTS; i++) begin
            lcg_state = lcg_step(lcg_state);
            cmd = pick_command(lcg_state);
            send_byte(cmd);
            {exp_rgb, exp_bright} = next_settings({exp_rgb, exp_bright}, cmd);
            idle_cycles(4);
            i_checker.compare_settings("one_byte", exp_rgb, exp_bright);
        end

        for (int i = 0; i < BRIGHT_TESTS; i++) begin
            lcg_state = lcg_step(lcg_state);
            send_byte("T");
            send_byte(lcg_state[23:16]);
            exp_bright = lcg_state[21:16];
            idle_cycles(4);
            i_checker.compare_settings("brightness", exp_rgb, exp_bright);
        end

        for (int i = 0; i < PIXEL_TESTS; i++) begin
            lcg_state = lcg_step(lcg_state);
            send_pixel("pixel", lcg_state);
        end
        drain_writes();
        idle_cycles(4);
        i_checker.compare_settings("pixel", exp_rgb, exp_bright);

        // whole RAM cleared, then one pixel after the sweep
        for (int a = 0; a < matrix_ctrl_pkg::RAM_WORDS; a++) begin
            i_checker.expect_write("blank", 12'(a), 8'h00, 1'b1);
        end
        send_byte("Z");
        lcg_state = lcg_step(lcg_state);
        send_pixel("pixel_after_blank", lcg_state);
        drain_writes();
        idle_cycles(4);
        i_checker.compare_settings("blank", exp_rgb, exp_bright);

        finish_run();
    end
endmodule

// ==== project.f ====
source/matrix_ctrl_pkg.sv
source/command_decoder.sv
source/arg_collector.sv
source/display_settings.sv
source/frame_ram_writer.sv
source/matrix_control_top.sv
verif/tb_clock_gen.sv
verif/tb_checker.sv
verif/matrix_control_asserts.sv
verif/tb_matrix_control.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the matrix control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
    -f project.f --top-module tb_matrix_control -o sim_matrix_control

./obj_dir/sim_matrix_control > sim.log 2>&1 || true
cat sim.log

grep -q "All tests passed!" sim.log
